// File: hdl/axi_pkg.sv
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // Channel payloads
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        resp_t             resp;
    } axil_r_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        resp_t resp;
    } axil_b_t;

    // Read-only master, used by instruction fetch
    typedef struct packed {
        logic     ar_valid;
        axil_ar_t ar;
        logic     r_ready;
    } axil_rd_req_t;

    typedef struct packed {
        logic    ar_ready;
        logic    r_valid;
        axil_r_t r;
    } axil_rd_rsp_t;

    // Full read/write bundles
    typedef struct packed {
        logic     ar_valid;
        axil_ar_t ar;
        logic     r_ready;
        logic     aw_valid;
        axil_aw_t aw;
        logic     w_valid;
        axil_w_t  w;
        logic     b_ready;
    } axil_req_t;

    typedef struct packed {
        logic    ar_ready;
        logic    r_valid;
        axil_r_t r;
        logic    aw_ready;
        logic    w_ready;
        logic    b_valid;
        axil_b_t b;
    } axil_rsp_t;

endpackage

// File: hdl/soc_pkg.sv
package soc_pkg;

    // Main memory
    localparam logic [axi_pkg::ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
    localparam int SRAM_WORDS = 1024;                  // 4 KiB
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

    // Machine timer
    localparam logic [axi_pkg::ADDR_W-1:0] CLINT_BASE   = 32'h0200_0000;
    localparam logic [axi_pkg::ADDR_W-1:0] CLINT_SPAN   = 32'h8;
    localparam logic [axi_pkg::ADDR_W-1:0] MTIME_LO_OFS = 32'h0;
    localparam logic [axi_pkg::ADDR_W-1:0] MTIME_HI_OFS = 32'h4;

endpackage

// File: hdl/axi_arbiter.sv
`timescale 1ns/1ns

module axi_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  axi_pkg::axil_rd_req_t fetch_req,
    output axi_pkg::axil_rd_rsp_t fetch_rsp,
    input  axi_pkg::axil_req_t    lsu_req,
    output axi_pkg::axil_rsp_t    lsu_rsp,
    output axi_pkg::axil_req_t    bus_req,
    input  axi_pkg::axil_rsp_t    bus_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH_RD,
        ST_LSU_RD,
        ST_LSU_WR
    } state_t;

    state_t state;
    state_t state_next;
    logic   fetch_gnt;
    logic   lsu_rd_gnt;
    logic   lsu_wr_gnt;
    logic   r_done;
    logic   b_done;

    assign fetch_gnt  = (state == ST_FETCH_RD);
    assign lsu_rd_gnt = (state == ST_LSU_RD);
    assign lsu_wr_gnt = (state == ST_LSU_WR);

    // Bus readies only reach the slave side from the owner
    assign r_done = bus_rsp.r_valid && bus_req.r_ready;
    assign b_done = bus_rsp.b_valid && bus_req.b_ready;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // Load/store wins a tie and writes go ahead of reads
                if (lsu_req.aw_valid || lsu_req.w_valid)
                    state_next = ST_LSU_WR;
                else if (lsu_req.ar_valid)
                    state_next = ST_LSU_RD;
                else if (fetch_req.ar_valid)
                    state_next = ST_FETCH_RD;
            end
            ST_FETCH_RD, ST_LSU_RD: if (r_done) state_next = ST_IDLE;
            ST_LSU_WR:              if (b_done) state_next = ST_IDLE;
            default:                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    // Owner's channels pass straight through and all else stays low
    always_comb begin
        bus_req    = '0;
        bus_req.ar = fetch_gnt ? fetch_req.ar : lsu_req.ar;
        bus_req.aw = lsu_req.aw;
        bus_req.w  = lsu_req.w;
        if (fetch_gnt) begin
            bus_req.ar_valid = fetch_req.ar_valid;
            bus_req.r_ready  = fetch_req.r_ready;
        end
        if (lsu_rd_gnt) begin
            bus_req.ar_valid = lsu_req.ar_valid;
            bus_req.r_ready  = lsu_req.r_ready;
        end
        if (lsu_wr_gnt) begin
            bus_req.aw_valid = lsu_req.aw_valid;
            bus_req.w_valid  = lsu_req.w_valid;
            bus_req.b_ready  = lsu_req.b_ready;
        end
    end

    always_comb begin
        fetch_rsp.r        = bus_rsp.r;      // Read payload reaches both masters
        fetch_rsp.ar_ready = fetch_gnt && bus_rsp.ar_ready;
        fetch_rsp.r_valid  = fetch_gnt && bus_rsp.r_valid;

        lsu_rsp.r        = bus_rsp.r;
        lsu_rsp.b        = bus_rsp.b;
        lsu_rsp.ar_ready = lsu_rd_gnt && bus_rsp.ar_ready;
        lsu_rsp.r_valid  = lsu_rd_gnt && bus_rsp.r_valid;
        lsu_rsp.aw_ready = lsu_wr_gnt && bus_rsp.aw_ready;
        lsu_rsp.w_ready  = lsu_wr_gnt && bus_rsp.w_ready;
        lsu_rsp.b_valid  = lsu_wr_gnt && bus_rsp.b_valid;
    end

    // Never both masters see bus activity in the same cycle
    a_grant_excl: assert property (@(posedge clk) disable iff (reset)
        !((fetch_rsp.ar_ready || fetch_rsp.r_valid) &&
          (lsu_rsp.ar_ready || lsu_rsp.r_valid || lsu_rsp.aw_ready || lsu_rsp.b_valid)))
        else $error("arbiter: fetch and load/store both granted");

endmodule

// File: hdl/addr_decoder.sv
`timescale 1ns/1ns

module addr_decoder (
    input  logic               clk,
    input  logic               reset,
    input  axi_pkg::axil_req_t bus_req,
    output axi_pkg::axil_rsp_t bus_rsp,
    output axi_pkg::axil_req_t sram_req,
    input  axi_pkg::axil_rsp_t sram_rsp,
    output axi_pkg::axil_req_t clint_req,
    input  axi_pkg::axil_rsp_t clint_rsp
);

    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_CLINT,
        TGT_ERR
    } tgt_t;

    localparam logic [axi_pkg::ADDR_W-1:0] SRAM_BYTES =
        axi_pkg::ADDR_W'(4 * soc_pkg::SRAM_WORDS);

    tgt_t rd_tgt;
    tgt_t wr_tgt;
    tgt_t tgt_q;         // Owner of the outstanding response
    logic pending;
    logic err_r_valid;
    logic err_b_valid;
    logic ar_fire;
    logic aw_fire;
    logic r_fire;
    logic b_fire;

    function automatic tgt_t decode(input logic [axi_pkg::ADDR_W-1:0] addr);
        if (addr >= soc_pkg::SRAM_BASE && addr < soc_pkg::SRAM_BASE + SRAM_BYTES)
            return TGT_SRAM;
        if (addr >= soc_pkg::CLINT_BASE && addr < soc_pkg::CLINT_BASE + soc_pkg::CLINT_SPAN)
            return TGT_CLINT;
        return TGT_ERR;
    endfunction

    assign rd_tgt  = decode(bus_req.ar.addr);
    assign wr_tgt  = decode(bus_req.aw.addr);
    assign ar_fire = bus_req.ar_valid && bus_rsp.ar_ready;
    assign aw_fire = bus_req.aw_valid && bus_rsp.aw_ready;
    assign r_fire  = bus_rsp.r_valid && bus_req.r_ready;
    assign b_fire  = bus_rsp.b_valid && bus_req.b_ready;

    // Address phase steered by live decode, response phase by tgt_q
    always_comb begin
        sram_req  = bus_req;
        clint_req = bus_req;

        sram_req.ar_valid  = bus_req.ar_valid && !pending && rd_tgt == TGT_SRAM;
        clint_req.ar_valid = bus_req.ar_valid && !pending && rd_tgt == TGT_CLINT;
        sram_req.aw_valid  = bus_req.aw_valid && !pending && wr_tgt == TGT_SRAM;
        clint_req.aw_valid = bus_req.aw_valid && !pending && wr_tgt == TGT_CLINT;
        sram_req.w_valid   = bus_req.w_valid && !pending && wr_tgt == TGT_SRAM;
        clint_req.w_valid  = bus_req.w_valid && !pending && wr_tgt == TGT_CLINT;

        sram_req.r_ready  = bus_req.r_ready && tgt_q == TGT_SRAM;
        clint_req.r_ready = bus_req.r_ready && tgt_q == TGT_CLINT;
        sram_req.b_ready  = bus_req.b_ready && tgt_q == TGT_SRAM;
        clint_req.b_ready = bus_req.b_ready && tgt_q == TGT_CLINT;
    end

    always_comb begin
        bus_rsp = '0;
        case (rd_tgt)
            TGT_SRAM:  bus_rsp.ar_ready = sram_rsp.ar_ready;
            TGT_CLINT: bus_rsp.ar_ready = clint_rsp.ar_ready;
            default:   bus_rsp.ar_ready = 1'b1;              // Error responder
        endcase
        case (wr_tgt)
            TGT_SRAM: begin
                bus_rsp.aw_ready = sram_rsp.aw_ready;
                bus_rsp.w_ready  = sram_rsp.w_ready;
            end
            TGT_CLINT: begin
                bus_rsp.aw_ready = clint_rsp.aw_ready;
                bus_rsp.w_ready  = clint_rsp.w_ready;
            end
            default: begin
                bus_rsp.aw_ready = bus_req.aw_valid && bus_req.w_valid;
                bus_rsp.w_ready  = bus_req.aw_valid && bus_req.w_valid;
            end
        endcase
        if (pending) begin
            bus_rsp.ar_ready = 1'b0;
            bus_rsp.aw_ready = 1'b0;
            bus_rsp.w_ready  = 1'b0;
        end

        case (tgt_q)
            TGT_SRAM: begin
                bus_rsp.r_valid = sram_rsp.r_valid;
                bus_rsp.r       = sram_rsp.r;
                bus_rsp.b_valid = sram_rsp.b_valid;
                bus_rsp.b       = sram_rsp.b;
            end
            TGT_CLINT: begin
                bus_rsp.r_valid = clint_rsp.r_valid;
                bus_rsp.r       = clint_rsp.r;
                bus_rsp.b_valid = clint_rsp.b_valid;
                bus_rsp.b       = clint_rsp.b;
            end
            default: begin
                bus_rsp.r_valid = err_r_valid;
                bus_rsp.r.resp  = axi_pkg::RESP_DECERR;   // Data stays zero
                bus_rsp.b_valid = err_b_valid;
                bus_rsp.b.resp  = axi_pkg::RESP_DECERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending     <= 1'b0;
            tgt_q       <= TGT_ERR;
            err_r_valid <= 1'b0;
            err_b_valid <= 1'b0;
        end else if (ar_fire) begin
            pending     <= 1'b1;
            tgt_q       <= rd_tgt;
            err_r_valid <= (rd_tgt == TGT_ERR);
        end else if (aw_fire) begin
            pending     <= 1'b1;
            tgt_q       <= wr_tgt;
            err_b_valid <= (wr_tgt == TGT_ERR);
        end else if (r_fire || b_fire) begin
            pending     <= 1'b0;
            err_r_valid <= 1'b0;
            err_b_valid <= 1'b0;
        end
    end

    // Relies on the arbiter never mixing a read and a write
    a_one_target: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sram_req.ar_valid || sram_req.aw_valid || sram_req.w_valid,
                  clint_req.ar_valid || clint_req.aw_valid || clint_req.w_valid}))
        else $error("decoder: two targets addressed at once");

endmodule

// File: hdl/sram_slave.sv
`timescale 1ns/1ns

module sram_slave (
    input  logic               clk,
    input  logic               reset,
    input  axi_pkg::axil_req_t req,
    output axi_pkg::axil_rsp_t rsp
);

    logic [axi_pkg::DATA_W-1:0]     mem [soc_pkg::SRAM_WORDS];
    logic [axi_pkg::ADDR_W-1:0]     rd_ofs;
    logic [axi_pkg::ADDR_W-1:0]     wr_ofs;
    logic [soc_pkg::SRAM_IDX_W-1:0] rd_idx;
    logic [soc_pkg::SRAM_IDX_W-1:0] wr_idx;
    logic [axi_pkg::DATA_W-1:0]     r_data_q;
    logic                           r_valid_q;
    logic                           b_valid_q;
    logic                           ar_fire;
    logic                           wr_fire;

    // Word index from the byte offset
    assign rd_ofs = req.ar.addr - soc_pkg::SRAM_BASE;
    assign wr_ofs = req.aw.addr - soc_pkg::SRAM_BASE;
    assign rd_idx = rd_ofs[soc_pkg::SRAM_IDX_W+1:2];
    assign wr_idx = wr_ofs[soc_pkg::SRAM_IDX_W+1:2];

    assign ar_fire = req.ar_valid && !r_valid_q;
    assign wr_fire = req.aw_valid && req.w_valid && !b_valid_q;  // Both channels together

    always_comb begin
        rsp          = '0;
        rsp.ar_ready = !r_valid_q;
        rsp.r_valid  = r_valid_q;
        rsp.r.data   = r_data_q;
        rsp.r.resp   = axi_pkg::RESP_OKAY;
        rsp.aw_ready = wr_fire;
        rsp.w_ready  = wr_fire;
        rsp.b_valid  = b_valid_q;
        rsp.b.resp   = axi_pkg::RESP_OKAY;
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < axi_pkg::STRB_W; i++) begin
                if (req.w.strb[i])
                    mem[wr_idx][8*i +: 8] <= req.w.data[8*i +: 8];
            end
        end
        if (ar_fire)
            r_data_q <= mem[rd_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_fire)
                r_valid_q <= 1'b1;
            else if (req.r_ready)
                r_valid_q <= 1'b0;
            if (wr_fire)
                b_valid_q <= 1'b1;
            else if (req.b_ready)
                b_valid_q <= 1'b0;
        end
    end

    // Stalled read data stays put until taken
    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        rsp.r_valid && !req.r_ready |=> rsp.r_valid && $stable(rsp.r))
        else $error("sram: r_valid dropped or data changed without handshake");

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
    input  logic               clk,
    input  logic               reset,
    input  axi_pkg::axil_req_t req,
    output axi_pkg::axil_rsp_t rsp
);

    logic [63:0]                mtime;
    logic [axi_pkg::ADDR_W-1:0] rd_ofs;
    logic [axi_pkg::ADDR_W-1:0] rd_word;
    axi_pkg::axil_r_t           r_q;
    logic                       r_valid_q;
    logic                       b_valid_q;
    logic                       ar_fire;
    logic                       wr_fire;

    assign rd_ofs  = req.ar.addr - soc_pkg::CLINT_BASE;
    assign rd_word = {rd_ofs[axi_pkg::ADDR_W-1:2], 2'b00};

    assign ar_fire = req.ar_valid && !r_valid_q;
    assign wr_fire = req.aw_valid && req.w_valid && !b_valid_q;

    always_comb begin
        rsp          = '0;
        rsp.ar_ready = !r_valid_q;
        rsp.r_valid  = r_valid_q;
        rsp.r        = r_q;
        rsp.aw_ready = wr_fire;
        rsp.w_ready  = wr_fire;
        rsp.b_valid  = b_valid_q;
        rsp.b.resp   = axi_pkg::RESP_SLVERR;    // Timer is read-only
    end

    // Snapshot taken at the address handshake
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            case (rd_word)
                soc_pkg::MTIME_LO_OFS: r_q <= '{data: mtime[31:0],  resp: axi_pkg::RESP_OKAY};
                soc_pkg::MTIME_HI_OFS: r_q <= '{data: mtime[63:32], resp: axi_pkg::RESP_OKAY};
                default:               r_q <= '{data: '0, resp: axi_pkg::RESP_SLVERR};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime     <= '0;
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar_fire)
                r_valid_q <= 1'b1;
            else if (req.r_ready)
                r_valid_q <= 1'b0;
            if (wr_fire)
                b_valid_q <= 1'b1;
            else if (req.b_ready)
                b_valid_q <= 1'b0;
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        rsp.b_valid && !req.b_ready |=> rsp.b_valid && $stable(rsp.b))
        else $error("clint: b_valid dropped without handshake");

endmodule

// File: hdl/mem_subsys.sv
`timescale 1ns/1ns

module mem_subsys (
    input  logic                  clk,
    input  logic                  reset,
    input  axi_pkg::axil_rd_req_t fetch_req,
    output axi_pkg::axil_rd_rsp_t fetch_rsp,
    input  axi_pkg::axil_req_t    lsu_req,
    output axi_pkg::axil_rsp_t    lsu_rsp
);

    axi_pkg::axil_req_t bus_req;      // Arbiter to decoder
    axi_pkg::axil_rsp_t bus_rsp;
    axi_pkg::axil_req_t sram_req;
    axi_pkg::axil_rsp_t sram_rsp;
    axi_pkg::axil_req_t clint_req;
    axi_pkg::axil_rsp_t clint_rsp;

    axi_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .lsu_req   (lsu_req),
        .lsu_rsp   (lsu_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

    addr_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .sram_req  (sram_req),
        .sram_rsp  (sram_rsp),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp)
    );

    sram_slave u_sram (
        .clk   (clk),
        .reset (reset),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

    clint_timer u_clint (
        .clk   (clk),
        .reset (reset),
        .req   (clint_req),
        .rsp   (clint_rsp)
    );

endmodule

// File: verif/tb_mem_subsys.sv
`timescale 1ns/1ns

module tb_mem_subsys;

    localparam int WAIT_LIMIT = 100;    // Cycles allowed per handshake wait
    localparam int N_RAND     = 60;
    localparam int AR_READY   = 0;
    localparam int R_VALID    = 1;
    localparam int WR_READY   = 2;
    localparam int B_VALID    = 3;

    logic                  clk;
    logic                  reset;
    axi_pkg::axil_rd_req_t fetch_req;
    axi_pkg::axil_rd_rsp_t fetch_rsp;
    axi_pkg::axil_req_t    lsu_req;
    axi_pkg::axil_rsp_t    lsu_rsp;

    logic [15:0] lfsr;
    logic [31:0] model_mem [soc_pkg::SRAM_WORDS];
    logic [31:0] last_mtime;
    logic        fetch_busy;      // Set from ar handshake to r handshake
    logic        lsu_rd_busy;
    logic        lsu_wr_busy;
    int          errors;
    int          test_errors;
    int          tx_count;
    int          total_tx;
    int          tests_done;

    mem_subsys dut (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .lsu_req   (lsu_req),
        .lsu_rsp   (lsu_rsp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Test slots spread over the whole SRAM
    function automatic logic [31:0] slot_addr(input logic [5:0] slot);
        return soc_pkg::SRAM_BASE + {20'h0, slot, 4'b0101, 2'b00};
    endfunction

    function automatic int slot_index(input logic [5:0] slot);
        return int'({slot, 4'b0101});
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hC3A5_0F1E;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] v;
        int          i;
        v = old;
        for (i = 0; i < 4; i++) begin
            if (strb[i])
                v[8*i +: 8] = data[8*i +: 8];
        end
        return v;
    endfunction

    function automatic logic probe(input int sel, input bit from_fetch);
        case (sel)
            AR_READY: return from_fetch ? fetch_rsp.ar_ready : lsu_rsp.ar_ready;
            R_VALID:  return from_fetch ? fetch_rsp.r_valid : lsu_rsp.r_valid;
            WR_READY: return lsu_rsp.aw_ready && lsu_rsp.w_ready;
            default:  return lsu_rsp.b_valid;
        endcase
    endfunction

    function automatic axi_pkg::axil_r_t r_of(input bit from_fetch);
        return from_fetch ? fetch_rsp.r : lsu_rsp.r;
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // Outputs sampled on the falling edge
    task automatic await_high(input int sel, input bit from_fetch, input string what);
        int t;
        t = 0;
        @(negedge clk);
        while (!probe(sel, from_fetch)) begin
            t++;
            if (t > WAIT_LIMIT)
                abort_run(what);
            @(negedge clk);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        test_errors++;
    endtask

    task automatic check_word(input string port, input axi_pkg::axil_r_t r,
                              input logic [31:0] exp);
        if (r.data !== exp)
            report_mismatch({port, ".r.data"}, r.data, exp);
        if (r.resp !== axi_pkg::RESP_OKAY)
            report_mismatch({port, ".r.resp"}, 32'(r.resp), 32'(axi_pkg::RESP_OKAY));
    endtask

    task automatic read_txn(input bit from_fetch, input logic [31:0] addr,
                            input int stall, output axi_pkg::axil_r_t r);
        axi_pkg::axil_r_t held;
        string            port;
        int               k;
        port = from_fetch ? "fetch_rsp" : "lsu_rsp";
        @(posedge clk);
        if (from_fetch) begin
            fetch_req.ar_valid <= 1'b1;
            fetch_req.ar.addr  <= addr;
        end else begin
            lsu_req.ar_valid <= 1'b1;
            lsu_req.ar.addr  <= addr;
        end
        await_high(AR_READY, from_fetch, {port, " ar_ready never rose"});
        @(posedge clk);                      // Address taken on this edge
        if (from_fetch) begin
            fetch_busy = 1'b1;
            fetch_req.ar_valid <= 1'b0;
        end else begin
            lsu_rd_busy = 1'b1;
            lsu_req.ar_valid <= 1'b0;
        end
        await_high(R_VALID, from_fetch, {port, " r_valid never rose"});
        r = r_of(from_fetch);
        for (k = 0; k < stall; k++) begin
            @(negedge clk);
            held = r_of(from_fetch);
            if (!probe(R_VALID, from_fetch)) begin
                $display("Error: %s r_valid fell while r_ready was low", port);
                test_errors++;
            end
            if (held.data !== r.data)
                report_mismatch({port, ".r.data"}, held.data, r.data);
            if (held.resp !== r.resp)
                report_mismatch({port, ".r.resp"}, 32'(held.resp), 32'(r.resp));
        end
        @(posedge clk);
        if (from_fetch)
            fetch_req.r_ready <= 1'b1;
        else
            lsu_req.r_ready <= 1'b1;
        @(posedge clk);                      // r handshake
        if (from_fetch) begin
            fetch_req.r_ready <= 1'b0;
            fetch_busy = 1'b0;
        end else begin
            lsu_req.r_ready <= 1'b0;
            lsu_rd_busy = 1'b0;
        end
        tx_count++;
    endtask

    task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall,
                             output axi_pkg::resp_t resp);
        int k;
        @(posedge clk);
        lsu_req.aw_valid <= 1'b1;
        lsu_req.aw.addr  <= addr;
        lsu_req.w_valid  <= 1'b1;
        lsu_req.w.data   <= data;
        lsu_req.w.strb   <= strb;
        await_high(WR_READY, 1'b0, "lsu_rsp aw_ready and w_ready never rose");
        @(posedge clk);
        lsu_wr_busy = 1'b1;
        lsu_req.aw_valid <= 1'b0;
        lsu_req.w_valid  <= 1'b0;
        await_high(B_VALID, 1'b0, "lsu_rsp b_valid never rose");
        resp = lsu_rsp.b.resp;
        for (k = 0; k < stall; k++) begin
            @(negedge clk);
            if (!lsu_rsp.b_valid) begin
                $display("Error: lsu_rsp b_valid fell while b_ready was low");
                test_errors++;
            end
            if (lsu_rsp.b.resp !== resp)
                report_mismatch("lsu_rsp.b.resp", 32'(lsu_rsp.b.resp), 32'(resp));
        end
        @(posedge clk);
        lsu_req.b_ready <= 1'b1;
        @(posedge clk);                      // b handshake
        lsu_req.b_ready <= 1'b0;
        lsu_wr_busy = 1'b0;
        tx_count++;
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("Test %0d %s: %0d transactions, %0d errors",
                 tests_done, name, tx_count, test_errors);
        errors      += test_errors;
        total_tx    += tx_count;
        test_errors = 0;
        tx_count    = 0;
    endtask

    // A response on a port with nothing outstanding went to the wrong master
    always @(negedge clk) begin
        if (!reset) begin
            if (fetch_rsp.r_valid && !fetch_busy) begin
                $display("Error: read data reached the fetch port with no fetch outstanding");
                test_errors++;
            end
            if (lsu_rsp.r_valid && !lsu_rd_busy) begin
                $display("Error: read data reached the load/store port unasked");
                test_errors++;
            end
            if (lsu_rsp.b_valid && !lsu_wr_busy) begin
                $display("Error: write response reached the load/store port unasked");
                test_errors++;
            end
        end
    end

    initial begin
        axi_pkg::axil_r_t r;
        axi_pkg::axil_r_t rf;
        axi_pkg::resp_t   b;
        logic [5:0]       slot;
        logic [5:0]       other;
        logic [31:0]      data;
        logic [31:0]      addr;
        logic [3:0]       strb;
        bit               do_write;
        bit               use_fetch;
        int               i;
        int               idx;

        fetch_req   = '0;
        lsu_req     = '0;
        reset       = 1'b1;
        lfsr        = 16'd56167;
        fetch_busy  = 1'b0;
        lsu_rd_busy = 1'b0;
        lsu_wr_busy = 1'b0;
        errors      = 0;
        test_errors = 0;
        tx_count    = 0;
        total_tx    = 0;
        tests_done  = 0;
        last_mtime  = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        repeat (4) begin
            @(negedge clk);
            if ({fetch_rsp.ar_ready, fetch_rsp.r_valid, lsu_rsp.ar_ready, lsu_rsp.r_valid,
                 lsu_rsp.aw_ready, lsu_rsp.w_ready, lsu_rsp.b_valid} !== 7'b0)
                report_mismatch("idle valid/ready outputs",
                                32'({fetch_rsp.ar_ready, fetch_rsp.r_valid, lsu_rsp.ar_ready,
                                     lsu_rsp.r_valid, lsu_rsp.aw_ready, lsu_rsp.w_ready,
                                     lsu_rsp.b_valid}), 32'h0);
        end
        finish_test("reset state");

        for (i = 0; i < 64; i++) begin
            addr = slot_addr(6'(i));
            write_txn(addr, fill_word(addr), 4'hF, 0, b);
            model_mem[slot_index(6'(i))] = fill_word(addr);
            if (b !== axi_pkg::RESP_OKAY)
                report_mismatch("lsu_rsp.b.resp", 32'(b), 32'(axi_pkg::RESP_OKAY));
        end
        for (i = 0; i < N_RAND; i++) begin
            slot = 6'(rand_bits(6));
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            idx  = slot_index(slot);
            write_txn(slot_addr(slot), data, strb, 0, b);
            model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
            if (b !== axi_pkg::RESP_OKAY)
                report_mismatch("lsu_rsp.b.resp", 32'(b), 32'(axi_pkg::RESP_OKAY));
            read_txn(1'b0, slot_addr(slot), 0, r);
            check_word("lsu_rsp", r, model_mem[idx]);
        end
        finish_test("sram byte writes");

        for (i = 0; i < N_RAND; i++) begin
            slot     = 6'(rand_bits(6));
            other    = slot + 6'd1;           // Never the fetched word
            do_write = (rand_bits(1) != 0);
            data     = rand_bits(32);
            strb     = 4'(rand_bits(4));
            if (i < 16) begin
                read_txn(1'b1, slot_addr(slot), 0, rf);
            end else begin
                fork
                    read_txn(1'b1, slot_addr(slot), 0, rf);
                    if (do_write)
                        write_txn(slot_addr(other), data, strb, 0, b);
                    else
                        read_txn(1'b0, slot_addr(other), 0, r);
                join
                idx = slot_index(other);
                if (do_write) begin
                    model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
                    if (b !== axi_pkg::RESP_OKAY)
                        report_mismatch("lsu_rsp.b.resp", 32'(b), 32'(axi_pkg::RESP_OKAY));
                end else begin
                    check_word("lsu_rsp", r, model_mem[idx]);
                end
            end
            check_word("fetch_rsp", rf, model_mem[slot_index(slot)]);
        end
        finish_test("fetch and arbitration");

        for (i = 0; i < 16; i++) begin
            slot = 6'(rand_bits(6));
            case (rand_bits(2))
                0:       addr = 32'h4000_0000 | (rand_bits(16) << 2);
                1:       addr = slot_addr(slot) + 32'h1000;     // Aliases the slot
                2:       addr = soc_pkg::CLINT_BASE + soc_pkg::CLINT_SPAN + (rand_bits(8) << 2);
                default: addr = 32'hFFFF_FFFC;
            endcase
            if (rand_bits(1) != 0) begin
                write_txn(addr, rand_bits(32), 4'hF, 0, b);
                if (b !== axi_pkg::RESP_DECERR)
                    report_mismatch("lsu_rsp.b.resp", 32'(b), 32'(axi_pkg::RESP_DECERR));
            end else begin
                read_txn(1'b0, addr, 0, r);
                if (r.resp !== axi_pkg::RESP_DECERR)
                    report_mismatch("lsu_rsp.r.resp", 32'(r.resp), 32'(axi_pkg::RESP_DECERR));
                if (r.data !== 32'h0)
                    report_mismatch("lsu_rsp.r.data", r.data, 32'h0);
            end
            read_txn(1'b1, slot_addr(slot), 0, rf);
            check_word("fetch_rsp", rf, model_mem[slot_index(slot)]);
        end
        finish_test("unmapped addresses");

        for (i = 0; i < 8; i++) begin
            read_txn(1'b0, soc_pkg::CLINT_BASE + soc_pkg::MTIME_LO_OFS, rand_bits(2), r);
            if (r.resp !== axi_pkg::RESP_OKAY)
                report_mismatch("lsu_rsp.r.resp", 32'(r.resp), 32'(axi_pkg::RESP_OKAY));
            if (r.data <= last_mtime) begin
                $display("CHECK FAILED lsu_rsp.r.data: mtime 0x%08h not above 0x%08h",
                         r.data, last_mtime);
                test_errors++;
            end
            last_mtime = r.data;
        end
        read_txn(1'b0, soc_pkg::CLINT_BASE + soc_pkg::MTIME_HI_OFS, 0, r);
        check_word("lsu_rsp", r, 32'h0);           // No wrap within one run
        write_txn(soc_pkg::CLINT_BASE, rand_bits(32), 4'hF, 0, b);
        if (b !== axi_pkg::RESP_SLVERR)
            report_mismatch("lsu_rsp.b.resp", 32'(b), 32'(axi_pkg::RESP_SLVERR));
        finish_test("machine timer");

        for (i = 0; i < N_RAND; i++) begin
            slot = 6'(rand_bits(6));
            idx  = slot_index(slot);
            if (rand_bits(1) != 0) begin
                data = rand_bits(32);
                strb = 4'(rand_bits(4));
                write_txn(slot_addr(slot), data, strb, rand_bits(4), b);
                model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
                if (b !== axi_pkg::RESP_OKAY)
                    report_mismatch("lsu_rsp.b.resp", 32'(b), 32'(axi_pkg::RESP_OKAY));
            end else begin
                use_fetch = (rand_bits(1) != 0);
                read_txn(use_fetch, slot_addr(slot), rand_bits(4), r);
                check_word(use_fetch ? "fetch_rsp" : "lsu_rsp", r, model_mem[idx]);
            end
        end
        finish_test("back-pressure");

        $display("Summary: %0d tests, %0d transactions, %0d errors",
                 tests_done, total_tx, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/axi_pkg.sv
hdl/soc_pkg.sv
hdl/axi_arbiter.sv
hdl/addr_decoder.sv
hdl/sram_slave.sv
hdl/clint_timer.sv
hdl/mem_subsys.sv
verif/tb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsys -f all.f -o sim_mem_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_subsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
